//--- src/fc_pkg.sv
package fc_pkg;

    // partial sums and results, signed
    localparam int PSUM_W = 8;

    // scratch word
    localparam int ACC_W = 32;

    // job size limits
    localparam int NODE_W = 7;   // up to 127 nodes
    localparam int TILE_W = 4;   // up to 15 tiles

    // one scratch word per possible node
    localparam int ACC_DEPTH  = 128;
    localparam int ACC_ADDR_W = $clog2(ACC_DEPTH);

    // result clamp range
    localparam logic signed [ACC_W-1:0] SAT_MAX = 127;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -128;

endpackage

//--- src/simple_dual_one_clock.sv
`timescale 1ns/1ps

module simple_dual_one_clock #(
    parameter int SRAM_DEPTH = 1024,
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          wea,
    input  logic                          enb,
    input  logic [$clog2(SRAM_DEPTH)-1:0] addra,
    input  logic [$clog2(SRAM_DEPTH)-1:0] addrb,
    input  logic [DATA_WIDTH-1:0]         dia,
    output logic [DATA_WIDTH-1:0]         dob
);

    logic [DATA_WIDTH-1:0] mem [SRAM_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dia;
        end
    end

    // read port, data one cycle after enb
    always_ff @(posedge clk) begin
        if (enb) begin
            dob <= mem[addrb];
        end
    end

endmodule

//--- src/fc_accumulator.sv
`timescale 1ns/1ps

module fc_accumulator (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [fc_pkg::PSUM_W-1:0] psum_i,   // bottom row of the array column
    input  logic                      pvalid_i,
    input  logic [fc_pkg::NODE_W-1:0] out_node_num_i,
    input  logic [fc_pkg::TILE_W-1:0] tile_num_i,
    input  logic                      relu_en_i,
    output logic                      fc_valid_o,
    output logic                      last_o,
    output logic [fc_pkg::PSUM_W-1:0] fc_result_o,
    output logic                      relu_en_o
);

    import fc_pkg::*;

    typedef enum logic [2:0] {
        S_INIT,
        S_ACC,
        S_FWRITE,
        S_OUT,
        S_LAST
    } state_t;

    state_t state, state_n;

    logic [NODE_W-1:0]     node_cnt, node_cnt_n;
    logic [TILE_W-1:0]     tile_cnt, tile_cnt_n;
    logic [ACC_ADDR_W-1:0] rd_ptr, rd_ptr_n;
    logic [ACC_ADDR_W-1:0] wr_ptr;
    logic [ACC_ADDR_W-1:0] rd_addr;

    // job config, captured at the first strobe
    logic [NODE_W-1:0] node_last;
    logic [TILE_W-1:0] tile_last;
    logic              relu_q;
    logic [NODE_W-1:0] cur_node_last;
    logic [TILE_W-1:0] cur_tile_last;

    logic strobe;
    logic capture;
    logic rd_en;
    logic out_rd;

    // write-back stage
    logic [PSUM_W-1:0]       psum_d;
    logic [TILE_W-1:0]       tile_d;
    logic                    pvalid_d;
    logic                    fwd_hit;
    logic [ACC_W-1:0]        fwd_sum;
    logic signed [ACC_W-1:0] ram_q;
    logic [ACC_W-1:0]        psum_ext;
    logic [ACC_W-1:0]        addend;
    logic [ACC_W-1:0]        sum;
    logic [PSUM_W-1:0]       sat;

    assign strobe  = pvalid_i && (state == S_INIT || state == S_ACC);
    assign capture = pvalid_i && (state == S_INIT);

    // first strobe sees the job size straight from the ports
    assign cur_node_last = capture ? out_node_num_i - 1'b1 : node_last;
    assign cur_tile_last = capture ? tile_num_i - 1'b1 : tile_last;

    assign rd_en   = strobe || (state == S_OUT);
    assign rd_addr = (state == S_OUT) ? rd_ptr : node_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_INIT;
            node_cnt <= '0;
            tile_cnt <= '0;
            rd_ptr   <= '0;
            pvalid_d <= 1'b0;
            fwd_hit  <= 1'b0;
            out_rd   <= 1'b0;
        end else begin
            state    <= state_n;
            node_cnt <= node_cnt_n;
            tile_cnt <= tile_cnt_n;
            rd_ptr   <= rd_ptr_n;
            pvalid_d <= strobe;
            // same word read while it is being written (one node per tile)
            fwd_hit  <= strobe && pvalid_d && (wr_ptr == node_cnt);
            out_rd   <= (state == S_OUT);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            node_last <= '0;
            tile_last <= '0;
            relu_q    <= 1'b0;
        end else if (capture) begin
            node_last <= cur_node_last;
            tile_last <= cur_tile_last;
            relu_q    <= relu_en_i;   // held until the next job starts
        end
    end

    always_ff @(posedge clk) begin
        psum_d  <= psum_i;
        tile_d  <= tile_cnt;
        wr_ptr  <= node_cnt;
        fwd_sum <= sum;
    end

    always_comb begin
        state_n    = state;
        node_cnt_n = node_cnt;
        tile_cnt_n = tile_cnt;
        rd_ptr_n   = rd_ptr;

        case (state)
            S_INIT, S_ACC: begin
                if (strobe) begin
                    if (node_cnt == cur_node_last) begin
                        node_cnt_n = '0;
                        if (tile_cnt == cur_tile_last) begin
                            tile_cnt_n = '0;
                            state_n    = S_FWRITE;   // final strobe of the job
                        end else begin
                            tile_cnt_n = tile_cnt + 1'b1;
                            state_n    = S_ACC;
                        end
                    end else begin
                        node_cnt_n = node_cnt + 1'b1;
                        state_n    = S_ACC;
                    end
                end
            end
            S_FWRITE: begin
                rd_ptr_n = '0;   // last write-back goes out this cycle
                state_n  = S_OUT;
            end
            S_OUT: begin
                if (rd_ptr == node_last) begin
                    state_n = S_LAST;
                end else begin
                    rd_ptr_n = rd_ptr + 1'b1;
                end
            end
            S_LAST: begin
                state_n = S_INIT;
            end
            default: begin
                state_n = S_INIT;
            end
        endcase
    end

    // tile 0 starts from zero, the scratch word is stale
    always_comb begin
        psum_ext = {{(ACC_W-PSUM_W){psum_d[PSUM_W-1]}}, psum_d};
        if (tile_d == '0) begin
            addend = '0;
        end else if (fwd_hit) begin
            addend = fwd_sum;
        end else begin
            addend = ram_q;
        end
        sum = psum_ext + addend;
    end

    always_comb begin
        if (ram_q > SAT_MAX) begin
            sat = SAT_MAX[PSUM_W-1:0];
        end else if (ram_q < SAT_MIN) begin
            sat = SAT_MIN[PSUM_W-1:0];
        end else begin
            sat = ram_q[PSUM_W-1:0];
        end
    end

    simple_dual_one_clock #(
        .SRAM_DEPTH (ACC_DEPTH),
        .DATA_WIDTH (ACC_W)
    ) acc_ram_inst (
        .clk   (clk),
        .wea   (pvalid_d),
        .enb   (rd_en),
        .addra (wr_ptr),
        .addrb (rd_addr),
        .dia   (sum),
        .dob   (ram_q)
    );

    assign fc_valid_o  = out_rd;   // read data lands one cycle after the read
    assign last_o      = (state == S_LAST);
    assign fc_result_o = sat;
    assign relu_en_o   = relu_q;

endmodule

//--- src/fc_activation.sv
`timescale 1ns/1ps

module fc_activation (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      fc_valid_i,
    input  logic                      last_i,
    input  logic [fc_pkg::PSUM_W-1:0] fc_result_i,
    input  logic                      relu_en_i,
    output logic                      act_valid_o,
    output logic                      act_last_o,
    output logic [fc_pkg::PSUM_W-1:0] act_data_o,
    output logic [fc_pkg::NODE_W-1:0] act_node_o
);

    import fc_pkg::*;

    logic [NODE_W-1:0] node_cnt;
    logic [PSUM_W-1:0] act_data;

    // relu or bypass
    always_comb begin
        if (relu_en_i && fc_result_i[PSUM_W-1]) begin
            act_data = '0;
        end else begin
            act_data = fc_result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            act_valid_o <= 1'b0;
            act_last_o  <= 1'b0;
            node_cnt    <= '0;
        end else begin
            act_valid_o <= fc_valid_i;
            act_last_o  <= fc_valid_i && last_i;
            if (fc_valid_i) begin
                node_cnt <= last_i ? '0 : node_cnt + 1'b1;   // restart per job
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fc_valid_i) begin
            act_data_o <= act_data;
            act_node_o <= node_cnt;
        end
    end

endmodule

//--- src/fc_layer_top.sv
`timescale 1ns/1ps

module fc_layer_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [fc_pkg::PSUM_W-1:0] psum_i,
    input  logic                      pvalid_i,
    input  logic [fc_pkg::NODE_W-1:0] out_node_num_i,
    input  logic [fc_pkg::TILE_W-1:0] tile_num_i,
    input  logic                      relu_en_i,
    output logic                      act_valid_o,
    output logic                      act_last_o,
    output logic [fc_pkg::PSUM_W-1:0] act_data_o,
    output logic [fc_pkg::NODE_W-1:0] act_node_o
);

    import fc_pkg::*;

    // accumulator to activation
    logic              fc_valid;
    logic              fc_last;
    logic [PSUM_W-1:0] fc_result;
    logic              fc_relu_en;

    fc_accumulator fc_accumulator_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .psum_i         (psum_i),
        .pvalid_i       (pvalid_i),
        .out_node_num_i (out_node_num_i),
        .tile_num_i     (tile_num_i),
        .relu_en_i      (relu_en_i),
        .fc_valid_o     (fc_valid),
        .last_o         (fc_last),
        .fc_result_o    (fc_result),
        .relu_en_o      (fc_relu_en)
    );

    fc_activation fc_activation_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fc_valid_i  (fc_valid),
        .last_i      (fc_last),
        .fc_result_i (fc_result),
        .relu_en_i   (fc_relu_en),
        .act_valid_o (act_valid_o),
        .act_last_o  (act_last_o),
        .act_data_o  (act_data_o),
        .act_node_o  (act_node_o)
    );

endmodule

//--- tb/fc_layer_properties.sv
`timescale 1ns/1ps

module fc_layer_properties (
    input logic clk,
    input logic rst_n,
    input logic pvalid_i,
    input logic strobe,
    input logic fc_valid_o,
    input logic last_o
);

    int fail_count = 0;   // read by the testbench at the end

    last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        last_o |-> fc_valid_o)
        else begin
            fail_count++;
            $error("last_o high without fc_valid_o");
        end

    // nothing comes out right after reset
    valid_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !fc_valid_o)
        else begin
            fail_count++;
            $error("fc_valid_o high in the first cycle after reset");
        end

    // strobe is only taken while idle or accumulating
    no_pvalid_in_output: assert property (@(posedge clk) disable iff (!rst_n)
        pvalid_i |-> strobe)
        else begin
            fail_count++;
            $error("pvalid_i high while the accumulator is reading out");
        end

endmodule

bind fc_accumulator fc_layer_properties fc_layer_properties_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .pvalid_i   (pvalid_i),
    .strobe     (strobe),
    .fc_valid_o (fc_valid_o),
    .last_o     (last_o)
);

//--- tb/fc_layer_checker.sv
`timescale 1ns/1ps

module fc_layer_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      act_valid_i,
    input logic                      act_last_i,
    input logic [fc_pkg::PSUM_W-1:0] act_data_i,
    input logic [fc_pkg::NODE_W-1:0] act_node_i
);

    import fc_pkg::*;

    string             test_name = "none";
    logic [PSUM_W-1:0] exp_data_q[$];
    logic [NODE_W-1:0] exp_node_q[$];
    logic              exp_last_q[$];
    logic [PSUM_W-1:0] e_data;
    logic [NODE_W-1:0] e_node;
    logic              e_last;
    int                test_errors = 0;
    int                error_count = 0;
    int                tests_done = 0;
    int                tests_passed = 0;

    task automatic start_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic push_expected(logic [PSUM_W-1:0] data, logic [NODE_W-1:0] node, logic last);
        exp_data_q.push_back(data);
        exp_node_q.push_back(node);
        exp_last_q.push_back(last);
    endtask

    function automatic int pending();
        return exp_data_q.size();
    endfunction

    // outputs settle after the rising edge
    always @(negedge clk) begin
        if (rst_n && act_last_i && !act_valid_i) begin
            $display("test %s: act_last_o high without a result", test_name);
            test_errors++;
            error_count++;
        end
        if (rst_n && act_valid_i) begin
            if (exp_data_q.size() == 0) begin
                $display("test %s: the DUT gave a result when none was expected", test_name);
                error_count++;
            end else begin
                e_data = exp_data_q.pop_front();
                e_node = exp_node_q.pop_front();
                e_last = exp_last_q.pop_front();
                if (act_data_i !== e_data || act_node_i !== e_node) begin
                    if (test_errors == 0) begin
                        $display("mismatch test %s: expected %0d at node %0d, actual %0d at node %0d",
                                 test_name, $signed(e_data), e_node, $signed(act_data_i),
                                 act_node_i);
                    end
                    test_errors++;
                    error_count++;
                end
                if (act_last_i !== e_last) begin
                    $display("test %s: act_last_o %s", test_name,
                             e_last ? "missing on the final result" : "high before the final result");
                    test_errors++;
                    error_count++;
                end
                if (e_last) begin
                    tests_done++;
                    if (test_errors == 0) begin
                        tests_passed++;
                        $display("test %s: pass", test_name);
                    end
                end
            end
        end
    end

endmodule

//--- tb/fc_layer_tb.sv
`timescale 1ns/1ps

module fc_layer_tb;

    import fc_pkg::*;

    localparam int RAND = 0;
    localparam int POS = 1;
    localparam int NEG = 2;
    localparam int RAMP = 3;

    logic              clk;
    logic              rst_n;
    logic              pvalid_i;
    logic              relu_en_i;
    logic              act_valid_o;
    logic              act_last_o;
    logic [PSUM_W-1:0] psum_i;
    logic [PSUM_W-1:0] act_data_o;
    logic [NODE_W-1:0] out_node_num_i;
    logic [NODE_W-1:0] act_node_o;
    logic [TILE_W-1:0] tile_num_i;

    // stimulus table, one entry per job
    string name_q[$];
    int    nodes_q[$];
    int    tiles_q[$];
    int    relu_q[$];
    int    mode_q[$];
    int    gap_q[$];

    logic signed [PSUM_W-1:0] psum_tbl [15][128];
    int seed = 66332;
    int timeout_cycles = 0;
    int total_errors;

    always #5 clk = ~clk;

    fc_layer_top fc_layer_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .psum_i         (psum_i),
        .pvalid_i       (pvalid_i),
        .out_node_num_i (out_node_num_i),
        .tile_num_i     (tile_num_i),
        .relu_en_i      (relu_en_i),
        .act_valid_o    (act_valid_o),
        .act_last_o     (act_last_o),
        .act_data_o     (act_data_o),
        .act_node_o     (act_node_o)
    );

    fc_layer_checker fc_layer_checker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .act_valid_i (act_valid_o),
        .act_last_i  (act_last_o),
        .act_data_i  (act_data_o),
        .act_node_i  (act_node_o)
    );

    task automatic add_row(string name, int nodes, int tiles, int relu, int mode, int gap);
        name_q.push_back(name);
        nodes_q.push_back(nodes);
        tiles_q.push_back(tiles);
        relu_q.push_back(relu);
        mode_q.push_back(mode);
        gap_q.push_back(gap);
    endtask

    task automatic run_row(int r);
        int sum;
        int idle;
        fc_layer_checker_inst.start_test(name_q[r]);
        for (int t = 0; t < tiles_q[r]; t++) begin
            for (int n = 0; n < nodes_q[r]; n++) begin
                case (mode_q[r])
                    POS:     psum_tbl[t][n] = 100;
                    NEG:     psum_tbl[t][n] = -100;
                    RAMP:    psum_tbl[t][n] = n * 3 + t - 15;
                    default: psum_tbl[t][n] = $random(seed) % 48;
                endcase
            end
        end
        // sum over tiles, clamp, then relu
        for (int n = 0; n < nodes_q[r]; n++) begin
            sum = 0;
            for (int t = 0; t < tiles_q[r]; t++) begin
                sum += psum_tbl[t][n];
            end
            if (sum > 127) begin
                sum = 127;
            end else if (sum < -128) begin
                sum = -128;
            end
            if (relu_q[r] != 0 && sum < 0) begin
                sum = 0;
            end
            fc_layer_checker_inst.push_expected(PSUM_W'(sum), NODE_W'(n), n == nodes_q[r] - 1);
        end
        for (int t = 0; t < tiles_q[r]; t++) begin
            for (int n = 0; n < nodes_q[r]; n++) begin
                @(posedge clk);
                pvalid_i       <= 1'b1;
                psum_i         <= psum_tbl[t][n];
                out_node_num_i <= NODE_W'(nodes_q[r]);
                tile_num_i     <= TILE_W'(tiles_q[r]);
                relu_en_i      <= relu_q[r][0];
                idle = gap_q[r] ? ($random(seed) & 1) : 0;
                repeat (idle) begin
                    @(posedge clk);
                    pvalid_i <= 1'b0;
                end
            end
        end
        @(posedge clk);
        pvalid_i <= 1'b0;
        do @(negedge clk); while (!act_last_o);
        @(posedge clk);   // checker is done with this job
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        psum_i         = '0;
        pvalid_i       = 1'b0;
        out_node_num_i = '0;
        tile_num_i     = '0;
        relu_en_i      = 1'b0;

        add_row("single_tile_rand", 16, 1, 0, RAND, 0);
        add_row("multi_tile_rand", 24, 6, 0, RAND, 0);
        add_row("pos_saturation", 8, 15, 0, POS, 0);
        add_row("neg_saturation", 8, 15, 0, NEG, 0);
        add_row("neg_saturation_relu", 8, 15, 1, NEG, 0);
        add_row("relu_rand", 32, 4, 1, RAND, 0);
        add_row("gapped_ramp", 10, 3, 0, RAMP, 1);
        add_row("single_node", 1, 5, 0, RAND, 0);
        add_row("full_nodes_gapped", 127, 2, 0, RAND, 1);

        for (int r = 0; r < name_q.size(); r++) begin
            timeout_cycles += nodes_q[r] * tiles_q[r] * 4;
        end
        timeout_cycles += 20;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < name_q.size(); r++) begin
            run_row(r);
        end

        total_errors = fc_layer_checker_inst.error_count
                     + fc_layer_top_inst.fc_accumulator_inst.fc_layer_properties_inst.fail_count;
        if (fc_layer_checker_inst.pending() != 0) begin
            $display("%0d expected results never came out of the DUT",
                     fc_layer_checker_inst.pending());
            total_errors++;
        end
        $display("tests %0d, passed %0d, errors %0d", fc_layer_checker_inst.tests_done,
                 fc_layer_checker_inst.tests_passed, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // budget grows with the size of every job
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

//--- list.f
src/fc_pkg.sv
src/simple_dual_one_clock.sv
src/fc_accumulator.sv
src/fc_activation.sv
src/fc_layer_top.sv
tb/fc_layer_properties.sv
tb/fc_layer_checker.sv
tb/fc_layer_tb.sv

//--- Bender.yml
package:
  name: fc_layer

sources:
  - files:
      - src/fc_pkg.sv
      - src/simple_dual_one_clock.sv
      - src/fc_accumulator.sv
      - src/fc_activation.sv
      - src/fc_layer_top.sv
  - target: test
    files:
      - tb/fc_layer_properties.sv
      - tb/fc_layer_checker.sv
      - tb/fc_layer_tb.sv
